// File: cpu8_pkg.sv
package cpu8_pkg;

    // Basic widths of the machine
    typedef logic [7:0] data_t;         // Bus and register word
    typedef logic [3:0] addr_t;         // RAM address and PC value
    typedef logic [3:0] opcode_t;       // Upper nibble of an instruction

    localparam int RAM_DEPTH = 16;      // Whole address space of the 4-bit MAR

    // Opcode map
    localparam opcode_t OP_LDA = 4'h0;  // A <= RAM[op]
    localparam opcode_t OP_ADD = 4'h1;  // A <= A + RAM[op]
    localparam opcode_t OP_SUB = 4'h2;  // A <= A - RAM[op]
    localparam opcode_t OP_STA = 4'h3;  // RAM[op] <= A
    localparam opcode_t OP_LDI = 4'h4;  // A <= {0, op}
    localparam opcode_t OP_JMP = 4'h5;  // PC <= op
    localparam opcode_t OP_JC  = 4'h6;  // Jump on carry
    localparam opcode_t OP_JZ  = 4'h7;  // Jump on zero
    localparam opcode_t OP_OUT = 4'he;  // Out register <= A
    localparam opcode_t OP_HLT = 4'hf;  // Stop the sequencer

    // Sequencer steps
    typedef enum logic [2:0] {
        T1,                             // MAR <= PC
        T2,                             // PC + 1
        T3,                             // IR <= RAM
        T4,                             // First execute step
        T5,
        T6,
        HALT                            // Parked until reset or program mode
    } step_e;

    // Internal bus source select
    typedef enum logic [2:0] {
        NONE,                           // Bus reads zero
        PC,
        RAM,
        IR_OPERAND,                     // Low nibble of IR, zero extended
        ACC,
        ALU
    } bus_src_e;

    // Control word, all fields active high
    typedef struct packed {
        logic     inc_pc;
        logic     load_pc;
        logic     load_mar;
        logic     write_ram;            // RAM[MAR] <= A
        logic     load_ir;
        logic     load_a;
        logic     load_b;
        logic     sub;                  // ALU subtracts instead of adds
        logic     load_flags;
        logic     load_out;
        bus_src_e bus_src;
    } ctrl_t;

endpackage

// File: program_counter.sv
`timescale 1ns/100ps

module program_counter import cpu8_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  hold,     // Program mode keeps the PC at zero
    input  ctrl_t ctrl,
    input  data_t bus,
    output addr_t pc
);

    // Jump target is the low nibble of the bus
    addr_t bus_addr;

    assign bus_addr = bus[3:0];

    // Clear has priority over load, load over count
    always_ff @(posedge clk) begin
        if (!rst_n || hold) begin
            pc <= '0;                   // Start of program
        end else if (ctrl.load_pc) begin
            pc <= bus_addr;             // JMP or taken JC/JZ
        end else if (ctrl.inc_pc) begin
            pc <= pc + addr_t'(1);      // Wraps from 15 to 0
        end
    end

endmodule

// File: memory_unit.sv
`timescale 1ns/100ps

module memory_unit import cpu8_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t ctrl,
    input  data_t bus,          // Address source for the MAR
    input  data_t acc,          // Store data for STA
    input  logic  prog_we,      // External program load strobe
    input  addr_t prog_addr,
    input  data_t prog_data,
    output data_t ram_data      // Asynchronous read at MAR
);

    addr_t mar;                         // Memory address register
    data_t mem [RAM_DEPTH];             // 16 x 8 program and data store

    // MAR loads from the low nibble of the bus
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (ctrl.load_mar) begin
            mar <= bus[3:0];            // PC in T1 or operand in T4
        end
    end

    // Two write ports folded into one
    // Program port wins over a CPU store
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;    // Loader path
        end else if (ctrl.write_ram) begin
            mem[mar] <= acc;                // STA in T5
        end
    end

    // Combinational read so the IR and A can load in the same step
    assign ram_data = mem[mar];

endmodule

// File: alu.sv
`timescale 1ns/100ps

module alu import cpu8_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t ctrl,
    input  data_t acc,
    input  data_t b_value,
    output data_t result,   // Combinational sum or difference
    output logic  cf,       // Registered carry flag
    output logic  zf        // Registered zero flag
);

    data_t      operand_b;              // B or its inverse
    logic [8:0] sum;                    // Carry in bit 8

    // Subtract is A + ~B + 1
    assign operand_b = ctrl.sub ? ~b_value : b_value;
    assign sum       = {1'b0, acc} + {1'b0, operand_b} + {8'd0, ctrl.sub};
    assign result    = sum[7:0];

    // Flags follow ADD and SUB only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (ctrl.load_flags) begin
            cf <= sum[8];               // For SUB set when A >= B
            zf <= (result == '0);
        end
    end

endmodule

// File: cpu_datapath.sv
`timescale 1ns/100ps

module cpu_datapath import cpu8_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ctrl_t   ctrl,
    input  addr_t   pc,
    input  data_t   ram_data,
    input  data_t   alu_result,
    output data_t   bus,            // Internal multiplexed bus
    output data_t   acc,            // Accumulator A
    output data_t   b_value,        // B register toward the ALU
    output opcode_t opcode,         // IR upper nibble
    output data_t   out_value,      // Output register
    output logic    out_strobe      // One cycle after an OUT load
);

    data_t ir;                      // Instruction register
    data_t operand;                 // IR low nibble zero extended

    assign operand = {4'h0, ir[3:0]};
    assign opcode  = ir[7:4];

    // Bus source select replaces the tri-state bus
    always_comb begin
        case (ctrl.bus_src)
            PC:         bus = {4'h0, pc};
            RAM:        bus = ram_data;
            IR_OPERAND: bus = operand;  // Address, immediate or jump target
            ACC:        bus = acc;
            ALU:        bus = alu_result;
            default:    bus = '0;       // Idle bus
        endcase
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ctrl.load_ir) begin
            ir <= bus;                  // Fetch in T3
        end
    end

    // Accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (ctrl.load_a) begin
            acc <= bus;                 // LDA, LDI or ALU result
        end
    end

    // B register feeds the ALU only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_value <= '0;
        end else if (ctrl.load_b) begin
            b_value <= bus;
        end
    end

    // Output register and its strobe
    // Value and strobe change on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_value  <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= ctrl.load_out;
            if (ctrl.load_out) begin
                out_value <= bus;       // A on the bus in T4 of OUT
            end
        end
    end

endmodule

// File: control_block.sv
`timescale 1ns/100ps

module control_block import cpu8_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    hold,       // Program mode parks the sequencer at T1
    input  opcode_t opcode,
    input  logic    cf,
    input  logic    zf,
    output ctrl_t   ctrl,
    output logic    halted
);

    step_e step;
    step_e step_next;
    logic  jump_taken;              // Condition for JMP, JC and JZ

    // Step sequencer
    always_ff @(posedge clk) begin
        if (!rst_n || hold) begin
            step <= T1;
        end else begin
            step <= step_next;
        end
    end

    // Six steps per instruction unless HLT parks in HALT after T4
    always_comb begin
        case (step)
            T1:      step_next = T2;
            T2:      step_next = T3;
            T3:      step_next = T4;
            T4:      step_next = (opcode == OP_HLT) ? HALT : T5;
            T5:      step_next = T6;
            T6:      step_next = T1;
            default: step_next = HALT;  // HALT holds
        endcase
    end

    always_comb begin
        case (opcode)
            OP_JMP:  jump_taken = 1'b1;
            OP_JC:   jump_taken = cf;
            OP_JZ:   jump_taken = zf;
            default: jump_taken = 1'b0;
        endcase
    end

    // Microcode decode
    always_comb begin
        ctrl         = '0;
        ctrl.bus_src = NONE;
        case (step)
            T1: begin                       // Address the next instruction
                ctrl.bus_src  = PC;
                ctrl.load_mar = 1'b1;
            end
            T2: ctrl.inc_pc = 1'b1;
            T3: begin                       // Fetch
                ctrl.bus_src = RAM;
                ctrl.load_ir = 1'b1;
            end
            T4: begin
                case (opcode)
                    OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                        ctrl.bus_src  = IR_OPERAND; // Point MAR at the operand
                        ctrl.load_mar = 1'b1;
                    end
                    OP_LDI: begin
                        ctrl.bus_src = IR_OPERAND;
                        ctrl.load_a  = 1'b1;
                    end
                    OP_JMP, OP_JC, OP_JZ: begin
                        ctrl.bus_src = IR_OPERAND;
                        ctrl.load_pc = jump_taken;  // Untaken jumps fall through
                    end
                    OP_OUT: begin
                        ctrl.bus_src  = ACC;
                        ctrl.load_out = 1'b1;
                    end
                    default: ;                      // HLT and unused opcodes
                endcase
            end
            T5: begin
                case (opcode)
                    OP_LDA: begin
                        ctrl.bus_src = RAM;
                        ctrl.load_a  = 1'b1;
                    end
                    OP_ADD, OP_SUB: begin
                        ctrl.bus_src = RAM;
                        ctrl.load_b  = 1'b1;        // Second operand into B
                    end
                    OP_STA:  ctrl.write_ram = 1'b1;
                    default: ;
                endcase
            end
            T6: begin
                if (opcode == OP_ADD || opcode == OP_SUB) begin
                    ctrl.bus_src    = ALU;
                    ctrl.sub        = (opcode == OP_SUB);
                    ctrl.load_a     = 1'b1;
                    ctrl.load_flags = 1'b1;         // Flags track the same result
                end
            end
            default: ;                              // HALT drives nothing
        endcase
    end

    assign halted = (step == HALT);

endmodule

// File: cpu8_top.sv
`timescale 1ns/100ps

module cpu8_top import cpu8_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  prog_en,      // Program mode holds the CPU at address 0
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  data_t prog_data,
    output data_t out_value,
    output logic  out_strobe,
    output logic  halted
);

    ctrl_t   ctrl;              // Control word from the sequencer
    data_t   bus;               // Multiplexed internal bus
    data_t   acc;
    data_t   b_value;
    data_t   ram_data;          // RAM read at MAR
    data_t   alu_result;
    addr_t   pc;
    opcode_t opcode;            // IR upper nibble to the decoder
    logic    cf;
    logic    zf;

    program_counter pc0 (
        .clk  (clk),
        .rst_n(rst_n),
        .hold (prog_en),
        .ctrl (ctrl),
        .bus  (bus),
        .pc   (pc)
    );

    memory_unit mem0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .bus      (bus),
        .acc      (acc),
        .prog_we  (prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .ram_data (ram_data)
    );

    alu alu0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .acc    (acc),
        .b_value(b_value),
        .result (alu_result),
        .cf     (cf),
        .zf     (zf)
    );

    cpu_datapath dp0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .pc        (pc),
        .ram_data  (ram_data),
        .alu_result(alu_result),
        .bus       (bus),
        .acc       (acc),
        .b_value   (b_value),
        .opcode    (opcode),
        .out_value (out_value),
        .out_strobe(out_strobe)
    );

    control_block cb0 (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (prog_en),
        .opcode(opcode),
        .cf    (cf),
        .zf    (zf),
        .ctrl  (ctrl),
        .halted(halted)
    );

endmodule

// File: tb_cpu8.sv
`timescale 1ns/100ps

module tb_cpu8 import cpu8_pkg::*; ();

    localparam int RESET_CYCLES     = 16;
    localparam int BUDGET           = 64;   // Instruction limit per program in the model
    localparam int POST_HALT_CYCLES = 50;
    localparam int NUM_PROGRAMS     = 27;   // 7 directed plus 20 random
    localparam int RUN_LIMIT        = BUDGET * 6 + 20;
    localparam int PROG_OVERHEAD    = RESET_CYCLES + RAM_DEPTH + POST_HALT_CYCLES + 20;
    localparam int WATCHDOG_CYCLES  = NUM_PROGRAMS * (RUN_LIMIT + PROG_OVERHEAD) + 200;

    typedef data_t image_t [RAM_DEPTH];     // One full RAM image

    logic  clk;
    logic  rst_n;
    logic  prog_en;
    logic  prog_we;
    addr_t prog_addr;
    data_t prog_data;
    data_t out_value;
    logic  out_strobe;
    logic  halted;

    data_t       got_q [$];                 // Values seen on out_strobe
    logic [31:0] lcg_state;
    int          data_errors;
    int          flag_errors;
    int          other_errors;              // Missing or extra strobes

    cpu8_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_value (out_value),
        .out_strobe(out_strobe),
        .halted    (halted)
    );

    always #5 clk = ~clk;

    // Collect outputs mid-cycle where they are stable
    always @(negedge clk) begin
        if (rst_n && out_strobe) begin
            got_q.push_back(out_value);
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ISA model that runs one instruction per loop pass
    function automatic void cpu_model(input image_t image, input int budget,
                                      output data_t outs [$], output logic halts);
        image_t     mem;
        addr_t      pc;
        data_t      a;
        data_t      ir;
        logic       cf;
        logic       zf;
        logic [8:0] sum;
        int         n;
        mem   = image;
        pc    = '0;
        a     = '0;
        cf    = 1'b0;
        zf    = 1'b0;
        halts = 1'b0;
        outs.delete();
        for (n = 0; n < budget && !halts; n++) begin
            ir = mem[pc];
            pc = pc + 4'd1;                 // Wraps at 16
            case (ir[7:4])
                OP_LDA: a = mem[ir[3:0]];
                OP_ADD, OP_SUB: begin
                    if (ir[7:4] == OP_SUB) begin
                        sum = {1'b0, a} + {1'b0, ~mem[ir[3:0]]} + 9'd1;
                    end else begin
                        sum = {1'b0, a} + {1'b0, mem[ir[3:0]]};
                    end
                    a  = sum[7:0];
                    cf = sum[8];            // Carry out that also means no borrow on SUB
                    zf = (a == 8'h00);
                end
                OP_STA: mem[ir[3:0]] = a;
                OP_LDI: a = {4'h0, ir[3:0]};
                OP_JMP: pc = ir[3:0];
                OP_JC:  if (cf) pc = ir[3:0];
                OP_JZ:  if (zf) pc = ir[3:0];
                OP_OUT: outs.push_back(a);
                OP_HLT: halts = 1'b1;
                default: ;                  // Unused opcodes do nothing
            endcase
        end
    endfunction

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %02h, actual %02h", name, expected, actual);
            data_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0b, actual %0b", name, expected, actual);
            flag_errors++;
        end
    endtask

    // Background bytes differ per address
    task automatic fill_image(output image_t img);
        int i;
        for (i = 0; i < RAM_DEPTH; i++) begin
            img[i] = data_t'(i * 7) ^ 8'hA5;
        end
    endtask

    // SUB result out, then 1 on borrow, 2 on zero, 3 on A > B
    task automatic build_branch(output image_t img, input data_t a, input data_t b);
        fill_image(img);
        img[0]  = {OP_LDA, 4'hE};
        img[1]  = {OP_SUB, 4'hF};
        img[2]  = {OP_OUT, 4'h0};
        img[3]  = {OP_JZ,  4'h8};
        img[4]  = {OP_JC,  4'hA};
        img[5]  = {OP_LDI, 4'h1};
        img[6]  = {OP_OUT, 4'h0};
        img[7]  = {OP_HLT, 4'h0};
        img[8]  = {OP_LDI, 4'h2};
        img[9]  = {OP_JMP, 4'h6};
        img[10] = {OP_LDI, 4'h3};
        img[11] = {OP_JMP, 4'h6};
        img[14] = a;
        img[15] = b;
    endtask

    // 11 random instructions, HLT, then 4 data bytes
    task automatic build_random(output image_t img);
        logic [31:0] r;
        int          i;
        for (i = 0; i < RAM_DEPTH; i++) begin
            lcg_state = lcg_step(lcg_state);
            r         = lcg_state;
            case (int'(r[23:16]) % 5)
                0:       img[i] = {OP_LDI, r[31:28]};
                1:       img[i] = {OP_ADD, 2'b11, r[29:28]};  // Data area only
                2:       img[i] = {OP_SUB, 2'b11, r[29:28]};
                3:       img[i] = {OP_STA, 2'b11, r[29:28]};
                default: img[i] = {OP_OUT, 4'h0};
            endcase
            if (i == 11) img[i] = {OP_HLT, 4'h0};
            if (i > 11) img[i] = r[15:8];
        end
    endtask

    task automatic run_program(input string name, input image_t image);
        data_t exp_q [$];
        logic  exp_halt;
        logic  halt_held;
        int    cycles;
        int    seen;
        int    i;
        cpu_model(image, BUDGET, exp_q, exp_halt);
        @(negedge clk);
        rst_n   = 1'b0;
        prog_en = 1'b1;                     // Sequencer parked while loading
        repeat (RESET_CYCLES) @(negedge clk);
        got_q.delete();
        rst_n = 1'b1;
        for (i = 0; i < RAM_DEPTH; i++) begin
            prog_we   = 1'b1;
            prog_addr = addr_t'(i);
            prog_data = image[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        prog_en = 1'b0;                     // Fetch from 0 on the next edge
        cycles  = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        check_flag({name, " halted"}, exp_halt, halted);
        seen      = got_q.size();
        halt_held = 1'b1;
        repeat (POST_HALT_CYCLES) begin
            @(negedge clk);
            halt_held = halt_held & halted;
        end
        check_flag({name, " halted held"}, exp_halt, halt_held);
        if (got_q.size() != seen) begin
            $display("%s: %0d output strobes after halt", name, got_q.size() - seen);
            other_errors++;
        end
        if (got_q.size() != exp_q.size()) begin
            $display("%s: expected %0d output strobes but saw %0d",
                     name, exp_q.size(), got_q.size());
            other_errors++;
        end
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_data($sformatf("%s out[%0d]", name, i), exp_q[i], got_q[i]);
        end
    endtask

    initial begin
        image_t img;
        int     p;
        clk          = 1'b0;
        rst_n        = 1'b0;
        prog_en      = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        lcg_state    = 32'h3487;
        data_errors  = 0;
        flag_errors  = 0;
        other_errors = 0;

        fill_image(img);                    // 5 + 0x3A
        img[0]  = {OP_LDI, 4'h5};
        img[1]  = {OP_ADD, 4'hF};
        img[2]  = {OP_OUT, 4'h0};
        img[3]  = {OP_HLT, 4'h0};
        img[15] = 8'h3A;
        run_program("load_add", img);

        build_branch(img, 8'h55, 8'h55);
        run_program("sub_equal", img);
        build_branch(img, 8'h80, 8'h21);
        run_program("sub_greater", img);
        build_branch(img, 8'h10, 8'h40);
        run_program("sub_less", img);

        fill_image(img);                    // Store then reload through address 13
        img[0]  = {OP_LDI, 4'h9};
        img[1]  = {OP_ADD, 4'hF};
        img[2]  = {OP_STA, 4'hD};
        img[3]  = {OP_LDI, 4'h0};
        img[4]  = {OP_LDA, 4'hD};
        img[5]  = {OP_OUT, 4'h0};
        img[6]  = {OP_HLT, 4'h0};
        img[15] = 8'h70;
        run_program("store_load", img);

        fill_image(img);                    // Step by 0x30 until carry
        img[0]  = {OP_ADD, 4'hE};
        img[1]  = {OP_OUT, 4'h0};
        img[2]  = {OP_JC,  4'h4};
        img[3]  = {OP_JMP, 4'h0};
        img[4]  = {OP_HLT, 4'h0};
        img[14] = 8'h30;
        run_program("count_loop", img);

        fill_image(img);                    // Code after HLT must never run
        img[0] = {OP_LDI, 4'h7};
        img[1] = {OP_OUT, 4'h0};
        img[2] = {OP_HLT, 4'h0};
        img[3] = {OP_OUT, 4'h0};
        img[4] = {OP_JMP, 4'h1};
        run_program("halt", img);

        for (p = 0; p < 20; p++) begin
            build_random(img);
            run_program($sformatf("random_%0d", p), img);
        end

        $display("Errors: data %0d, flag %0d, strobe count %0d",
                 data_errors, flag_errors, other_errors);
        if (data_errors == 0 && flag_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: cpu8.f
cpu8_pkg.sv
program_counter.sv
memory_unit.sv
alu.sv
cpu_datapath.sv
control_block.sv
cpu8_top.sv
tb_cpu8.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_cpu8
DUT_TOP    = cpu8_top
FILELIST   = cpu8.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
